// ==== Bender.yml ====
package:
  name: sifh

export_include_dirs:
  - hw

sources:
  - hw/sifhPkg.sv
  - hw/streamSlice.sv
  - hw/histRam.sv
  - hw/acqRegs.sv
  - hw/histFsm.sv
  - hw/sifhTop.sv
  - target: test
    files:
      - dv/sifhTb.sv

// ==== dv/sifhTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module sifhTb import sifhPkg::*; ();

    localparam int period  = 40;
    localparam int cntMax  = (1 << `SIFH_CNT_W) - 1;
    localparam int nRandom = 200;
    localparam int nBurst  = 40;
    localparam int nSat    = 300;
    localparam int nTie    = 14;
    localparam int nSecond = 120;
    localparam int numRuns = 4;
    localparam int totalEv = nRandom + nBurst + nSat + nTie + nSecond;
    // clear, four pixel scans and register traffic per run
    localparam int runCycles = 64 + `SIFH_PIXELS * (`SIFH_BINS + 4) + 40;
    localparam int budget    = 4 * (4 * totalEv + numRuns * runCycles);

    logic                   clk = 1'b0;
    logic                   res;
    logic                   regWe;
    logic [1:0]             regAddr;
    logic [`SIFH_LEN_W-1:0] regWdata;
    logic [`SIFH_LEN_W-1:0] regRdata;
    logic                   evValid;
    logic                   evReady;
    photonEvT               evData;
    logic                   pkValid;
    logic                   pkReady;
    peakResT                pkData;

    int       refHist [`SIFH_PIXELS][`SIFH_BINS];
    photonEvT evQ[$];
    peakResT  expQ[$];
    int       errors   = 0;
    int       peakCnt  = 0;
    bit       bpOn     = 1'b0;
    string    testName = "reset";

    sifhTop DUT (
        .clk(clk), .res(res),
        .regWe(regWe), .regAddr(regAddr), .regWdata(regWdata), .regRdata(regRdata),
        .evValid(evValid), .evReady(evReady), .evData(evData),
        .pkValid(pkValid), .pkReady(pkReady), .pkData(pkData)
    );

    always #(period / 2) clk = ~clk;

    always @(posedge clk) begin
        pkReady <= bpOn ? ($urandom_range(0, 1) == 1) : 1'b1;
    end

    function automatic photonEvT makeEvent(input int p, input int b);
        photonEvT ev;
        ev.pixel = pixelT'(p);
        ev.bin   = binT'(b);
        return ev;
    endfunction

    // highest saturated count with the lowest bin winning a tie
    function automatic peakResT refPeak(input int p);
        peakResT r;
        int      c;
        r.pixel = pixelT'(p);
        r.bin   = '0;
        r.count = '0;
        for (int b = 0; b < `SIFH_BINS; b++) begin
            c = (refHist[p][b] > cntMax) ? cntMax : refHist[p][b];
            if (c > r.count) begin
                r.count = countT'(c);
                r.bin   = binT'(b);
            end
        end
        return r;
    endfunction

    task automatic checkPeak(input string name, input peakResT exp, input peakResT act);
        string e;
        string a;
        if (act !== exp) begin
            errors++;
            e = $sformatf("pixel %0d bin %0d count %0d", exp.pixel, exp.bin, exp.count);
            a = $sformatf("pixel %0d bin %0d count %0d", act.pixel, act.bin, act.count);
            $display("Mismatch %s: expected %s actual %s", name, e, a);
        end
    endtask

    task automatic checkReg(input string name, input logic [`SIFH_LEN_W-1:0] exp,
                            input logic [`SIFH_LEN_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected 0x%04h actual 0x%04h", name, exp, act);
        end
    endtask

    task automatic writeReg(input logic [1:0] a, input logic [`SIFH_LEN_W-1:0] d);
        regWe    <= 1'b1;
        regAddr  <= a;
        regWdata <= d;
        @(posedge clk);
        regWe    <= 1'b0;
    endtask

    task automatic readReg(input logic [1:0] a, output logic [`SIFH_LEN_W-1:0] d);
        regAddr <= a;
        @(posedge clk);
        d = regRdata; // combinational and settled before this edge
    endtask

    // drains evQ into the DUT and records what was accepted
    task automatic sendEvents(input bit gaps);
        photonEvT ev;
        while (evQ.size() != 0) begin
            ev = evQ.pop_front();
            if (gaps) begin
                repeat ($urandom_range(0, 3)) begin
                    evValid <= 1'b0;
                    @(posedge clk);
                end
            end
            evValid <= 1'b1;
            evData  <= ev;
            @(posedge clk);
            while (!evReady) @(posedge clk);
            refHist[ev.pixel][ev.bin]++;
        end
        evValid <= 1'b0;
    endtask

    task automatic runAcq(input string name, input bit gaps, input bit bp, input bit extraStart);
        logic [`SIFH_LEN_W-1:0] rd;
        int                     n;
        int                     peaksBefore;
        testName    = name;
        n           = evQ.size();
        peaksBefore = peakCnt;
        bpOn       <= bp;
        foreach (refHist[p, b]) refHist[p][b] = 0;
        writeReg(2'd0, n[`SIFH_LEN_W-1:0]);
        readReg(2'd0, rd);
        checkReg({name, " length"}, n[`SIFH_LEN_W-1:0], rd);
        writeReg(2'd1, 'h1);
        @(posedge clk);        // busy rises one cycle after the start pulse
        readReg(2'd2, rd);
        checkReg({name, " busy"}, 'h1, rd);
        if (extraStart) writeReg(2'd1, 'h1); // dropped while still clearing
        sendEvents(gaps);
        for (int p = 0; p < `SIFH_PIXELS; p++) expQ.push_back(refPeak(p));
        while (peakCnt < peaksBefore + `SIFH_PIXELS) @(posedge clk);
        repeat (20) @(posedge clk);
        readReg(2'd2, rd);
        checkReg({name, " idle"}, 'h0, rd);
        if (peakCnt != peaksBefore + `SIFH_PIXELS || expQ.size() != 0) begin
            errors++;
            $display("%s: expected %0d peaks but %0d arrived", name, `SIFH_PIXELS,
                     peakCnt - peaksBefore);
        end
        bpOn <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (res && pkValid && pkReady) begin
            peakCnt <= peakCnt + 1;
            if (expQ.size() == 0) begin
                errors++;
                $display("%s: peak for pixel %0d arrived with none expected", testName,
                         pkData.pixel);
            end else begin
                checkPeak(testName, expQ.pop_front(), pkData);
            end
        end
    end

    initial begin
        #(budget * period);
        $display("timeout: %s still running after %0d cycles", testName, budget);
        $display("error count %0d, peaks checked %0d", errors, peakCnt);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [`SIFH_LEN_W-1:0] rd;
        void'($urandom(32'hac23));
        res      = 1'b0;
        regWe    = 1'b0;
        regAddr  = '0;
        regWdata = '0;
        evValid  = 1'b0;
        evData   = '0;
        pkReady  = 1'b0;
        repeat (10) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        readReg(2'd2, rd);
        checkReg("reset status", 'h0, rd);

        repeat (nRandom) begin
            evQ.push_back(makeEvent($urandom_range(0, `SIFH_PIXELS - 1),
                                    $urandom_range(0, `SIFH_BINS - 1)));
        end
        runAcq("random", 1'b1, 1'b0, 1'b0);

        repeat (nBurst) evQ.push_back(makeEvent(2, 5)); // back to back to the same address
        runAcq("burst", 1'b0, 1'b0, 1'b0);

        for (int i = 0; i < nTie; i++) evQ.push_back(makeEvent(3, (i % 2) ? 12 : 4));
        repeat (nSat) evQ.push_back(makeEvent(1, 9));
        runAcq("saturate", 1'b0, 1'b0, 1'b0);

        repeat (nSecond) begin
            evQ.push_back(makeEvent($urandom_range(0, `SIFH_PIXELS - 1),
                                    $urandom_range(0, `SIFH_BINS - 1)));
        end
        runAcq("second run", 1'b1, 1'b1, 1'b1);

        $display("error count %0d, peaks checked %0d", errors, peakCnt);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/acqRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module acqRegs (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic                   regWe,
    input  wire logic [1:0]             regAddr,
    input  wire logic [`SIFH_LEN_W-1:0] regWdata,
    output logic      [`SIFH_LEN_W-1:0] regRdata,
    input  wire logic                   busy,
    output logic                        start,
    output logic      [`SIFH_LEN_W-1:0] acqLen
);

    localparam logic [1:0] addrLen    = 2'd0;
    localparam logic [1:0] addrCtrl   = 2'd1;
    localparam logic [1:0] addrStatus = 2'd2;

    logic startWr;

    assign startWr = regWe && (regAddr == addrCtrl) && regWdata[0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqLen <= '0;
            start  <= 1'b0;
        end else begin
            if (regWe && (regAddr == addrLen)) begin
                acqLen <= regWdata;
            end
            // a pulse in flight counts as busy too
            start <= startWr && !busy && !start;
        end
    end

    always_comb begin
        case (regAddr)
            addrLen:    regRdata = acqLen;
            addrStatus: regRdata = {{(`SIFH_LEN_W-1){1'b0}}, busy};
            default:    regRdata = '0; // control reads as zero
        endcase
    end

    // the engine never sees a second start mid-run
    aNoStartBusy: assert property (
        @(posedge clk) disable iff (!res)
        start |-> !busy
    );

endmodule

`default_nettype wire

// ==== hw/histFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module histFsm import sifhPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic                   start,
    input  wire logic [`SIFH_LEN_W-1:0] acqLen,
    output logic                        busy,
    input  wire logic                   evValid,
    output logic                        evReady,
    input  wire photonEvT               evData,
    output logic                        wrEn,
    output histAddrT                    wrAddr,
    output countT                       wrData,
    output logic                        rdEn,
    output histAddrT                    rdAddr,
    input  wire countT                  rdData,
    output logic                        pkValid,
    input  wire logic                   pkReady,
    output peakResT                     pkData
);

    typedef enum logic [2:0] {Idle, Clear, Accumulate, Drain, Scan, Emit} stateT;

    stateT state, stateNext;

    logic [`SIFH_LEN_W-1:0] lenQ;      // length latched at start
    logic [`SIFH_LEN_W-1:0] evCnt;
    logic [`SIFH_LEN_W-1:0] evCntNext;
    histAddrT               clrAddr;
    pixelT                  scanPix;
    binT                    scanBin;

    logic     accept;
    logic     p1Valid;                 // increment stage with RAM data present
    histAddrT p1Addr;
    logic     pendValid;               // write of the previous cycle
    histAddrT pendAddr;
    countT    pendData;
    countT    baseCnt;
    countT    incCnt;

    logic  cmpValid;                   // scan data returning from RAM
    logic  cmpFirst;
    binT   cmpBin;
    countT maxCnt;
    binT   maxBin;

    assign busy      = (state != Idle);
    assign evReady   = (state == Accumulate);
    assign accept    = evValid && evReady;
    assign evCntNext = evCnt + 1'b1;

    // forward the write that the RAM read just missed
    assign baseCnt = (pendValid && pendAddr == p1Addr) ? pendData : rdData;
    assign incCnt  = (baseCnt == '1) ? baseCnt : baseCnt + 1'b1;

    assign wrEn   = (state == Clear) || p1Valid;
    assign wrAddr = (state == Clear) ? clrAddr : p1Addr;
    assign wrData = (state == Clear) ? '0 : incCnt;
    assign rdEn   = accept || (state == Scan);
    assign rdAddr = (state == Scan) ? histAddrT'({scanPix, scanBin})
                                    : histAddrT'({evData.pixel, evData.bin});

    // hold off until the last bin has been compared
    assign pkValid = (state == Emit) && !cmpValid;
    assign pkData  = '{pixel: scanPix, bin: maxBin, count: maxCnt};

    always_comb begin
        stateNext = state;
        case (state)
            Idle:       if (start) stateNext = Clear;
            Clear:      if (clrAddr == '1) stateNext = (lenQ == '0) ? Scan : Accumulate;
            Accumulate: if (accept && evCntNext == lenQ) stateNext = Drain;
            Drain:      stateNext = Scan;   // last increment lands here
            Scan:       if (scanBin == '1) stateNext = Emit;
            Emit: begin
                if (pkValid && pkReady) begin
                    stateNext = (scanPix == '1) ? Idle : Scan;
                end
            end
            default:    stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= Idle;
            lenQ      <= '0;
            evCnt     <= '0;
            clrAddr   <= '0;
            scanPix   <= '0;
            scanBin   <= '0;
            p1Valid   <= 1'b0;
            pendValid <= 1'b0;
            cmpValid  <= 1'b0;
        end else begin
            state     <= stateNext;
            p1Valid   <= accept;
            pendValid <= p1Valid;
            cmpValid  <= (state == Scan);
            if (state == Idle && start) begin
                lenQ    <= acqLen;
                evCnt   <= '0;
                clrAddr <= '0;
                scanPix <= '0;
                scanBin <= '0;
            end
            if (state == Clear) clrAddr <= clrAddr + 1'b1;
            if (accept) evCnt <= evCntNext;
            if (state == Scan) scanBin <= scanBin + 1'b1;  // wraps to 0 for next pixel
            if (pkValid && pkReady) scanPix <= scanPix + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        p1Addr   <= histAddrT'({evData.pixel, evData.bin});
        pendAddr <= p1Addr;
        pendData <= incCnt;
        cmpFirst <= (scanBin == '0);
        cmpBin   <= scanBin;
        // strict compare keeps the lowest bin on a tie
        if (cmpValid && (cmpFirst || rdData > maxCnt)) begin
            maxCnt <= rdData;
            maxBin <= cmpBin;
        end
    end

    // Drain only carries the final increment of the accumulate pipeline
    aWrPhase: assert property (
        @(posedge clk) disable iff (!res)
        wrEn |-> state inside {Clear, Accumulate, Drain}
    );

    aEvPhase: assert property (
        @(posedge clk) disable iff (!res)
        evReady |-> busy && evCnt < lenQ
    );

    aPkHold: assert property (
        @(posedge clk) disable iff (!res)
        pkValid && !pkReady |=> pkValid && $stable(pkData)
    );

endmodule

`default_nettype wire

// ==== hw/histRam.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module histRam import sifhPkg::*; (
    input  wire logic     clk,
    input  wire logic     wrEn,
    input  wire histAddrT wrAddr,
    input  wire countT    wrData,
    input  wire logic     rdEn,
    input  wire histAddrT rdAddr,
    output countT         rdData
);

    localparam int depth = `SIFH_PIXELS * `SIFH_BINS;

    countT mem [depth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read gives old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/sifhCfg.svh ====
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// array geometry
`define SIFH_PIXELS 4
`define SIFH_BINS   16

// one saturating histogram count
`define SIFH_CNT_W  8

// acquisition length register in events
`define SIFH_LEN_W  16

`endif

// ==== hw/sifhPkg.sv ====
`default_nettype none

`include "sifhCfg.svh"

package sifhPkg;

    localparam int pixelW = $clog2(`SIFH_PIXELS);
    localparam int binW   = $clog2(`SIFH_BINS);

    typedef logic [pixelW-1:0]      pixelT;
    typedef logic [binW-1:0]        binT;
    typedef logic [`SIFH_CNT_W-1:0] countT;

    // pixel in the upper bits, bin in the lower
    typedef logic [pixelW+binW-1:0] histAddrT;

    // one detected photon
    typedef struct packed {
        pixelT pixel;
        binT   bin;
    } photonEvT;

    // peak of one pixel histogram
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } peakResT;

endpackage

`default_nettype wire

// ==== hw/sifhTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sifhCfg.svh"

module sifhTop import sifhPkg::*; (
    input  wire logic                   clk,
    input  wire logic                   res,
    input  wire logic                   regWe,
    input  wire logic [1:0]             regAddr,
    input  wire logic [`SIFH_LEN_W-1:0] regWdata,
    output logic      [`SIFH_LEN_W-1:0] regRdata,
    input  wire logic                   evValid,
    output logic                        evReady,
    input  wire photonEvT               evData,
    output logic                        pkValid,
    input  wire logic                   pkReady,
    output peakResT                     pkData
);

    logic                   busy;
    logic                   start;
    logic [`SIFH_LEN_W-1:0] acqLen;

    logic     fsmEvValid;
    logic     fsmEvReady;
    photonEvT fsmEvData;
    logic     fsmPkValid;
    logic     fsmPkReady;
    peakResT  fsmPkData;

    logic     wrEn;
    histAddrT wrAddr;
    countT    wrData;
    logic     rdEn;
    histAddrT rdAddr;
    countT    rdData;

    streamSlice #(.payloadT(photonEvT)) uEvSlice (
        .clk(clk), .res(res),
        .inValid(evValid), .inReady(evReady), .inData(evData),
        .outValid(fsmEvValid), .outReady(fsmEvReady), .outData(fsmEvData)
    );

    acqRegs uRegs (
        .clk(clk), .res(res),
        .regWe(regWe), .regAddr(regAddr), .regWdata(regWdata), .regRdata(regRdata),
        .busy(busy), .start(start), .acqLen(acqLen)
    );

    histFsm uFsm (
        .clk(clk), .res(res),
        .start(start), .acqLen(acqLen), .busy(busy),
        .evValid(fsmEvValid), .evReady(fsmEvReady), .evData(fsmEvData),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData),
        .pkValid(fsmPkValid), .pkReady(fsmPkReady), .pkData(fsmPkData)
    );

    histRam uRam (
        .clk(clk),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdEn(rdEn), .rdAddr(rdAddr), .rdData(rdData)
    );

    streamSlice #(.payloadT(peakResT)) uPkSlice (
        .clk(clk), .res(res),
        .inValid(fsmPkValid), .inReady(fsmPkReady), .inData(fsmPkData),
        .outValid(pkValid), .outReady(pkReady), .outData(pkData)
    );

endmodule

`default_nettype wire

// ==== hw/streamSlice.sv ====
`timescale 1ns/1ps
`default_nettype none

// forward register stage for a valid/ready stream
module streamSlice #(
    parameter type payloadT = logic
) (
    input  wire logic     clk,
    input  wire logic     res,
    input  wire logic     inValid,
    output logic          inReady,
    input  wire payloadT  inData,
    output logic          outValid,
    input  wire logic     outReady,
    output payloadT       outData
);

    // free when empty or when the held item leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

    // a stalled item neither changes nor disappears
    aOutHold: assert property (
        @(posedge clk) disable iff (!res)
        outValid && !outReady |=> outValid && $stable(outData)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/sifhPkg.sv
hw/streamSlice.sv
hw/histRam.sv
hw/acqRegs.sv
hw/histFsm.sv
hw/sifhTop.sv
dv/sifhTb.sv
